//--- hw/axi_burst_writer.sv
`timescale 1ns/100ps
`default_nettype none

module axi_burst_writer (
  input  logic                                      clk,
  input  logic                                      rst,
  input  logic                                      start,
  input  logic [15:0]                               burst_count,
  output logic                                      busy,
  output logic                                      awvalid,
  output logic [axi_perf_pkg::axi_addr_width-1:0]   awaddr,
  output logic [axi_perf_pkg::axi_id_width-1:0]     awid,
  output logic [7:0]                                awlen,
  output logic [2:0]                                awsize,
  output logic [1:0]                                awburst,
  input  logic                                      awready,
  output logic                                      wvalid,
  output logic [axi_perf_pkg::axi_data_width-1:0]   wdata,
  output logic [axi_perf_pkg::axi_strb_width-1:0]   wstrb,
  output logic                                      wlast,
  input  logic                                      wready,
  input  logic                                      bvalid,
  input  logic [axi_perf_pkg::axi_id_width-1:0]     bid,
  input  logic [1:0]                                bresp,
  output logic                                      bready,
  output logic                                      report_valid,
  input  logic                                      report_ready,
  input  logic                                      done_pulse,
  output logic [15:0]                               bursts,
  output logic [31:0]                               beats,
  output logic [31:0]                               cycles,
  output logic [7:0]                                errors
);
  import axi_perf_pkg::*;

  writer_state_t state;
  logic [15:0] total;
  logic [beat_idx_width-1:0] beat_idx;
  logic report_seen;
  logic [31:0] burst_base;
  logic [31:0] lane;

  // Burst k starts at k * burst_bytes, every lane carries the beat address
  assign burst_base = 32'(bursts) * 32'(burst_bytes);
  assign lane = burst_base + 32'(beat_idx) * 32'(axi_strb_width);

  assign awvalid = state == wr_addr;
  assign awaddr = burst_base[axi_addr_width-1:0];
  assign awid = bursts[axi_id_width-1:0];
  assign awlen = axi_len;
  assign awsize = axi_size;
  assign awburst = axi_burst_incr;

  assign wvalid = state == wr_data;
  assign wdata = {lane_count{lane}};
  assign wstrb = '1;
  assign wlast = beat_idx == beat_idx_width'(burst_beats - 1);

  assign bready = state == wr_resp;

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= wr_idle;
      busy <= 1'b0;
      report_valid <= 1'b0;
      report_seen <= 1'b0;
      total <= '0;
      beat_idx <= '0;
      bursts <= '0;
      beats <= '0;
      cycles <= '0;
      errors <= '0;
    end else begin
      // The start cycle counts as one, stalls are counted too
      if (state == wr_addr || state == wr_data || state == wr_resp) begin
        cycles <= cycles + 32'd1;
      end

      case (state)
        wr_idle: begin
          if (start) begin
            busy <= 1'b1;
            total <= burst_count;
            bursts <= '0;
            beats <= '0;
            errors <= '0;
            cycles <= 32'd1;
            beat_idx <= '0;
            report_seen <= 1'b0;
            if (burst_count == 16'd0) begin
              report_valid <= 1'b1;
              state <= wr_report;
            end else begin
              state <= wr_addr;
            end
          end
        end

        wr_addr: begin
          if (awready) begin
            state <= wr_data;
          end
        end

        wr_data: begin
          if (wready) begin
            beats <= beats + 32'd1;
            beat_idx <= beat_idx + 1'b1;
            if (wlast) begin
              state <= wr_resp;
            end
          end
        end

        wr_resp: begin
          if (bvalid) begin
            bursts <= bursts + 16'd1;
            if (bresp != resp_okay && errors != 8'hff) begin
              errors <= errors + 8'd1;
            end
            if (bursts + 16'd1 == total) begin
              report_valid <= 1'b1;
              state <= wr_report;
            end else begin
              state <= wr_addr;
            end
          end
        end

        wr_report: begin
          if (report_valid && report_ready) begin
            report_valid <= 1'b0;
            report_seen <= 1'b1;
          end
          if (report_seen && done_pulse) begin
            busy <= 1'b0;
            state <= wr_idle;
          end
        end

        default: state <= wr_idle;
      endcase
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~
  // Protocol checks
  // ~~~~~~~~~~~~~~~~~~~~
  assert property (@(posedge clk) disable iff (rst)
    awvalid && !awready |=> awvalid && $stable(awaddr) && $stable(awid));

  // The sixteenth beat of every burst is the only one with wlast
  assert property (@(posedge clk) disable iff (rst)
    wvalid && wready |-> wlast == ((beats % burst_beats) == burst_beats - 1));

  assert property (@(posedge clk) disable iff (rst)
    bvalid && bready |-> bid == awid);

endmodule

`default_nettype wire

//--- hw/axi_perf_pkg.sv
`default_nettype none

package axi_perf_pkg;

  // ~~~~~~~~~~~~~~~~~~~~
  // AXI bus shape
  // ~~~~~~~~~~~~~~~~~~~~
  localparam int axi_addr_width = 28;
  localparam int axi_data_width = 128;
  localparam int axi_strb_width = axi_data_width / 8;
  localparam int axi_id_width = 4;
  localparam int lane_count = axi_data_width / 32;

  localparam int burst_beats = 16;
  localparam int burst_bytes = burst_beats * axi_strb_width;
  localparam int beat_idx_width = $clog2(burst_beats);

  localparam logic [7:0] axi_len = 8'(burst_beats - 1);
  localparam logic [2:0] axi_size = 3'($clog2(axi_strb_width));
  localparam logic [1:0] axi_burst_incr = 2'b01;
  localparam logic [1:0] resp_okay = 2'b00;
  localparam logic [1:0] resp_slverr = 2'b10;

  // Target pacing
  localparam int wait_states = 2;
  localparam int wait_cnt_width = $clog2(wait_states + 1);

  // ~~~~~~~~~~~~~~~~~~~~
  // Report and UART
  // ~~~~~~~~~~~~~~~~~~~~
  localparam int clks_per_bit = 16;
  localparam int uart_cnt_width = $clog2(clks_per_bit);
  localparam int report_bytes = 16;
  localparam int report_idx_width = $clog2(report_bytes);
  localparam logic [7:0] report_sync = 8'ha5;

  typedef enum logic [2:0] {
    wr_idle,
    wr_addr,
    wr_data,
    wr_resp,
    wr_report
  } writer_state_t;

  typedef enum logic [1:0] {
    tg_idle,
    tg_wait,
    tg_accept,
    tg_resp
  } target_state_t;

  typedef enum logic [1:0] {
    ut_idle,
    ut_start,
    ut_data,
    ut_stop
  } uart_state_t;

endpackage

`default_nettype wire

//--- hw/axi_perf_top.sv
`timescale 1ns/100ps
`default_nettype none

module axi_perf_top (
  input  logic        clk,
  input  logic        rst,
  input  logic        start,
  input  logic [15:0] burst_count,
  output logic        busy,
  output logic        utx_pin
);
  import axi_perf_pkg::*;

  // ~~~~~~~~~~~~~~~~~~~~
  // AXI write path
  // ~~~~~~~~~~~~~~~~~~~~
  logic                      axi_awvalid;
  logic [axi_addr_width-1:0] axi_awaddr;
  logic [axi_id_width-1:0]   axi_awid;
  logic [7:0]                axi_awlen;
  logic [2:0]                axi_awsize;
  logic [1:0]                axi_awburst;
  logic                      axi_awready;
  logic                      axi_wvalid;
  logic [axi_data_width-1:0] axi_wdata;
  logic [axi_strb_width-1:0] axi_wstrb;
  logic                      axi_wlast;
  logic                      axi_wready;
  logic                      axi_bvalid;
  logic [axi_id_width-1:0]   axi_bid;
  logic [1:0]                axi_bresp;
  logic                      axi_bready;

  logic        report_valid;
  logic        report_ready;
  logic        done_pulse;
  logic [15:0] bursts;
  logic [31:0] beats;
  logic [31:0] cycles;
  logic [7:0]  errors;
  logic [31:0] signature;
  logic        byte_valid;
  logic [7:0]  byte_data;
  logic        byte_ready;
  logic        uart_idle;
  logic        clear;

  // Signature restarts with every accepted run
  assign clear = start && !busy;

  axi_burst_writer u_writer (
    .clk         (clk),
    .rst         (rst),
    .start       (start),
    .burst_count (burst_count),
    .busy        (busy),
    .awvalid     (axi_awvalid),
    .awaddr      (axi_awaddr),
    .awid        (axi_awid),
    .awlen       (axi_awlen),
    .awsize      (axi_awsize),
    .awburst     (axi_awburst),
    .awready     (axi_awready),
    .wvalid      (axi_wvalid),
    .wdata       (axi_wdata),
    .wstrb       (axi_wstrb),
    .wlast       (axi_wlast),
    .wready      (axi_wready),
    .bvalid      (axi_bvalid),
    .bid         (axi_bid),
    .bresp       (axi_bresp),
    .bready      (axi_bready),
    .report_valid(report_valid),
    .report_ready(report_ready),
    .done_pulse  (done_pulse),
    .bursts      (bursts),
    .beats       (beats),
    .cycles      (cycles),
    .errors      (errors)
  );

  axi_wr_target u_target (
    .clk      (clk),
    .rst      (rst),
    .clear    (clear),
    .awvalid  (axi_awvalid),
    .awaddr   (axi_awaddr),
    .awid     (axi_awid),
    .awlen    (axi_awlen),
    .awsize   (axi_awsize),
    .awburst  (axi_awburst),
    .awready  (axi_awready),
    .wvalid   (axi_wvalid),
    .wdata    (axi_wdata),
    .wstrb    (axi_wstrb),
    .wlast    (axi_wlast),
    .wready   (axi_wready),
    .bvalid   (axi_bvalid),
    .bid      (axi_bid),
    .bresp    (axi_bresp),
    .bready   (axi_bready),
    .signature(signature)
  );

  perf_reporter u_reporter (
    .clk         (clk),
    .rst         (rst),
    .report_valid(report_valid),
    .report_ready(report_ready),
    .bursts      (bursts),
    .beats       (beats),
    .cycles      (cycles),
    .errors      (errors),
    .signature   (signature),
    .byte_valid  (byte_valid),
    .byte_data   (byte_data),
    .byte_ready  (byte_ready),
    .done_pulse  (done_pulse)
  );

  uart_tx u_uart (
    .clk       (clk),
    .rst       (rst),
    .byte_valid(byte_valid),
    .byte_data (byte_data),
    .byte_ready(byte_ready),
    .idle      (uart_idle),
    .utx_pin   (utx_pin)
  );

  // The line is quiet whenever no run is in progress
  assert property (@(posedge clk) disable iff (rst) !busy |-> uart_idle && utx_pin);

endmodule

`default_nettype wire

//--- hw/axi_wr_target.sv
`timescale 1ns/100ps
`default_nettype none

module axi_wr_target (
  input  logic                                      clk,
  input  logic                                      rst,
  input  logic                                      clear,
  input  logic                                      awvalid,
  input  logic [axi_perf_pkg::axi_addr_width-1:0]   awaddr,
  input  logic [axi_perf_pkg::axi_id_width-1:0]     awid,
  input  logic [7:0]                                awlen,
  input  logic [2:0]                                awsize,
  input  logic [1:0]                                awburst,
  output logic                                      awready,
  input  logic                                      wvalid,
  input  logic [axi_perf_pkg::axi_data_width-1:0]   wdata,
  input  logic [axi_perf_pkg::axi_strb_width-1:0]   wstrb,
  input  logic                                      wlast,
  output logic                                      wready,
  output logic                                      bvalid,
  output logic [axi_perf_pkg::axi_id_width-1:0]     bid,
  output logic [1:0]                                bresp,
  input  logic                                      bready,
  output logic [31:0]                               signature
);
  import axi_perf_pkg::*;

  target_state_t state;
  logic [axi_addr_width-1:0] addr_q;
  logic [axi_id_width-1:0] id_q;
  logic [7:0] len_q;
  logic [7:0] beat_cnt;
  logic [wait_cnt_width-1:0] wait_cnt;
  logic [axi_data_width-1:0] masked;
  logic [31:0] fold;

  assign awready = state == tg_idle;
  assign wready = state == tg_accept;
  assign bvalid = state == tg_resp;
  assign bid = id_q;
  // Top address bit marks the error region
  assign bresp = addr_q[axi_addr_width-1] ? resp_slverr : resp_okay;

  always_comb begin
    fold = '0;
    for (int i = 0; i < axi_strb_width; i++) begin
      masked[i*8 +: 8] = wstrb[i] ? wdata[i*8 +: 8] : 8'h00;
    end
    for (int l = 0; l < lane_count; l++) begin
      fold = fold ^ masked[l*32 +: 32];
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= tg_idle;
      wait_cnt <= '0;
      beat_cnt <= '0;
      signature <= '0;
    end else begin
      case (state)
        tg_idle: begin
          if (awvalid) begin
            beat_cnt <= '0;
            wait_cnt <= '0;
            state <= tg_wait;
          end
        end

        // Exactly wait_states idle cycles before each accept cycle
        tg_wait: begin
          if (wvalid) begin
            if (wait_cnt == wait_cnt_width'(wait_states - 1)) begin
              wait_cnt <= '0;
              state <= tg_accept;
            end else begin
              wait_cnt <= wait_cnt + 1'b1;
            end
          end
        end

        tg_accept: begin
          if (wvalid) begin
            beat_cnt <= beat_cnt + 8'd1;
            state <= (beat_cnt == len_q) ? tg_resp : tg_wait;
          end
        end

        tg_resp: begin
          if (bready) begin
            state <= tg_idle;
          end
        end

        default: state <= tg_idle;
      endcase

      if (clear) begin
        signature <= '0;
      end else if (wvalid && wready) begin
        signature <= signature ^ fold;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (awvalid && awready) begin
      addr_q <= awaddr;
      id_q <= awid;
      len_q <= awlen;
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~
  // Protocol checks
  // ~~~~~~~~~~~~~~~~~~~~
  assert property (@(posedge clk) disable iff (rst)
    bvalid && !bready |=> bvalid && $stable(bresp) && $stable(bid));

  // Master's wlast must agree with the length taken from AW
  assert property (@(posedge clk) disable iff (rst)
    wvalid && wready |-> wlast == (beat_cnt == len_q));

  assert property (@(posedge clk) disable iff (rst)
    awvalid && awready |-> awburst == axi_burst_incr && awsize == axi_size);

endmodule

`default_nettype wire

//--- hw/perf_reporter.sv
`timescale 1ns/100ps
`default_nettype none

module perf_reporter (
  input  logic        clk,
  input  logic        rst,
  input  logic        report_valid,
  output logic        report_ready,
  input  logic [15:0] bursts,
  input  logic [31:0] beats,
  input  logic [31:0] cycles,
  input  logic [7:0]  errors,
  input  logic [31:0] signature,
  output logic        byte_valid,
  output logic [7:0]  byte_data,
  input  logic        byte_ready,
  output logic        done_pulse
);
  import axi_perf_pkg::*;

  typedef enum logic [1:0] {
    rp_idle,
    rp_send,
    rp_drain
  } rp_state_t;

  rp_state_t state;
  logic [report_bytes*8-1:0] frame;
  logic [report_idx_width-1:0] byte_idx;

  assign report_ready = state == rp_idle;
  assign byte_valid = state == rp_send;
  assign byte_data = frame[byte_idx*8 +: 8];

  // UART ready again means the last stop bit has gone out
  assign done_pulse = (state == rp_drain) && byte_ready;

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= rp_idle;
      byte_idx <= '0;
    end else begin
      case (state)
        rp_idle: begin
          if (report_valid) begin
            byte_idx <= '0;
            state <= rp_send;
          end
        end

        rp_send: begin
          if (byte_ready) begin
            if (byte_idx == report_idx_width'(report_bytes - 1)) begin
              state <= rp_drain;
            end else begin
              byte_idx <= byte_idx + 1'b1;
            end
          end
        end

        rp_drain: begin
          if (byte_ready) begin
            state <= rp_idle;
          end
        end

        default: state <= rp_idle;
      endcase
    end
  end

  // Byte 0 is the sync, fields follow LSB first
  always_ff @(posedge clk) begin
    if (report_valid && report_ready) begin
      frame <= {signature, errors, cycles, beats, bursts, report_sync};
    end
  end

endmodule

`default_nettype wire

//--- hw/uart_tx.sv
`timescale 1ns/100ps
`default_nettype none

module uart_tx (
  input  logic       clk,
  input  logic       rst,
  input  logic       byte_valid,
  input  logic [7:0] byte_data,
  output logic       byte_ready,
  output logic       idle,
  output logic       utx_pin
);
  import axi_perf_pkg::*;

  uart_state_t state;
  logic [uart_cnt_width-1:0] bit_cnt;
  logic [2:0] bit_idx;
  logic [7:0] shreg;
  logic bit_end;

  assign bit_end = bit_cnt == uart_cnt_width'(clks_per_bit - 1);
  assign byte_ready = state == ut_idle;
  assign idle = (state == ut_idle) && !byte_valid;

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= ut_idle;
      bit_cnt <= '0;
      bit_idx <= '0;
      utx_pin <= 1'b1;
    end else begin
      bit_cnt <= (state == ut_idle || bit_end) ? '0 : bit_cnt + 1'b1;
      case (state)
        ut_idle: begin
          if (byte_valid) begin
            shreg <= byte_data;
            utx_pin <= 1'b0;
            state <= ut_start;
          end
        end

        ut_start: begin
          if (bit_end) begin
            bit_idx <= '0;
            utx_pin <= shreg[0];
            state <= ut_data;
          end
        end

        // LSB first, the shift register drops each bit as it is sent
        ut_data: begin
          if (bit_end) begin
            if (bit_idx == 3'd7) begin
              utx_pin <= 1'b1;
              state <= ut_stop;
            end else begin
              bit_idx <= bit_idx + 3'd1;
              shreg <= {1'b0, shreg[7:1]};
              utx_pin <= shreg[1];
            end
          end
        end

        ut_stop: begin
          if (bit_end) begin
            state <= ut_idle;
          end
        end

        default: state <= ut_idle;
      endcase
    end
  end

endmodule

`default_nettype wire

//--- tb.f
hw/axi_perf_pkg.sv
hw/uart_tx.sv
hw/perf_reporter.sv
hw/axi_wr_target.sv
hw/axi_burst_writer.sv
hw/axi_perf_top.sv
testbench/tb_axi_perf.sv

//--- testbench/tb_axi_perf.sv
`timescale 1ns/100ps
`default_nettype none

module tb_axi_perf;
  import axi_perf_pkg::*;

  logic        clk;
  logic        rst;
  logic        start;
  logic [15:0] burst_count;
  logic        busy;
  logic        utx_pin;

  logic [7:0]                rx_bytes[$];
  logic [report_bytes*8-1:0] exp_frame;
  logic [15:0]               exp_count;
  logic [31:0]               lfsr_state;
  string                     test_name;
  int                        value_errors;
  int                        other_errors;
  event                      frame_done;

  axi_perf_top u_dut (
    .clk        (clk),
    .rst        (rst),
    .start      (start),
    .burst_count(burst_count),
    .busy       (busy),
    .utx_pin    (utx_pin)
  );

  always #50 clk = ~clk;

  // ~~~~~~~~~~~~~~~~~~~~
  // Reference model
  // ~~~~~~~~~~~~~~~~~~~~
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    // Taps 32, 22, 2, 1
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic random_burst_count(output logic [15:0] count);
    logic [5:0] bits;
    for (int i = 0; i < 6; i++) begin
      lfsr_state = lfsr_step(lfsr_state);
      bits[i] = lfsr_state[0];
    end
    count = 16'(bits % 40) + 16'd1;
  endtask

  // Frame bytes in order: sync, bursts, beats, cycles, errors, signature
  function automatic logic [report_bytes*8-1:0] reference_frame(input logic [15:0] count);
    logic [31:0]               sig;
    logic [31:0]               addr;
    logic [31:0]               lane;
    int                        errs;
    logic [report_bytes*8-1:0] frame;
    sig = '0;
    errs = 0;
    for (int k = 0; k < count; k++) begin
      addr = 32'(k) * 32'(burst_bytes);
      if (addr[axi_addr_width-1] && errs < 255) begin
        errs++;
      end
      for (int j = 0; j < burst_beats; j++) begin
        lane = addr + 32'(j) * 32'(axi_strb_width);
        for (int l = 0; l < lane_count; l++) begin
          sig = sig ^ lane;
        end
      end
    end
    frame = '0;
    frame[7:0] = report_sync;
    frame[23:8] = count;
    frame[55:24] = 32'(count) * 32'(burst_beats);
    frame[95:88] = 8'(errs);
    frame[127:96] = sig;
    return frame;
  endfunction

  // ~~~~~~~~~~~~~~~~~~~~
  // Checks and waits
  // ~~~~~~~~~~~~~~~~~~~~
  task automatic check_value(input string field, input logic [31:0] expected,
                             input logic [31:0] actual);
    assert (expected === actual) else begin
      value_errors++;
      $display("[ERROR] %s %s: expected %0h, actual %0h", test_name, field, expected, actual);
    end
  endtask

  task automatic abort_on_timeout(input string what);
    other_errors++;
    $display("Test %s timed out while waiting for %s", test_name, what);
    $display("Errors: %0d wrong values, %0d other failures", value_errors, other_errors);
    $display("SIMULATION FAILED");
    $finish;
  endtask

  task automatic wait_for_busy(input logic level, input int limit, input string what);
    int waited;
    waited = 0;
    while (busy !== level) begin
      @(negedge clk);
      waited++;
      if (waited > limit) begin
        abort_on_timeout(what);
      end
    end
  endtask

  task automatic check_line_quiet(input int n);
    int  i;
    logic quiet;
    i = 0;
    quiet = 1'b1;
    while (i < n && quiet) begin
      @(negedge clk);
      assert (utx_pin === 1'b1 && busy === 1'b0) else begin
        other_errors++;
        quiet = 1'b0;
        $display("Test %s: UART line or busy active at cycle %0d of the quiet window",
                 test_name, i);
      end
      i++;
    end
  endtask

  // Samples each bit near its middle, clks_per_bit clocks apart
  task automatic receive_byte(input int limit, output logic [7:0] data);
    int waited;
    waited = 0;
    while (utx_pin !== 1'b0) begin
      @(negedge clk);
      waited++;
      if (waited > limit) begin
        abort_on_timeout("a UART start bit");
      end
    end
    repeat (clks_per_bit / 2) @(negedge clk);
    assert (utx_pin === 1'b0) else begin
      other_errors++;
      $display("Test %s: UART start bit did not stay low", test_name);
    end
    for (int i = 0; i < 8; i++) begin
      repeat (clks_per_bit) @(negedge clk);
      data[i] = utx_pin;
    end
    repeat (clks_per_bit) @(negedge clk);
    assert (utx_pin === 1'b1) else begin
      other_errors++;
      $display("Test %s: UART stop bit missing", test_name);
    end
  endtask

  task automatic receive_frame;
    logic [7:0] b;
    rx_bytes.delete();
    for (int i = 0; i < report_bytes; i++) begin
      receive_byte(8000, b);
      rx_bytes.push_back(b);
    end
  endtask

  task automatic run_once(input string name, input logic [15:0] count,
                          input logic extra_start, input logic [15:0] extra_count);
    test_name = name;
    exp_frame = reference_frame(count);
    exp_count = count;
    start = 1'b1;
    burst_count = count;
    @(negedge clk);
    start = 1'b0;
    wait_for_busy(1'b1, 10, "busy to rise");
    if (extra_start) begin
      repeat (5) @(negedge clk);
      start = 1'b1;
      burst_count = extra_count;
      @(negedge clk);
      start = 1'b0;
      burst_count = count;
    end
    receive_frame();
    -> frame_done;
    wait_for_busy(1'b0, 4 * clks_per_bit, "busy to fall");
    // Long enough for a second frame to show up if one were sent
    check_line_quiet(20 * clks_per_bit);
  endtask

  // ~~~~~~~~~~~~~~~~~~~~
  // Frame comparison
  // ~~~~~~~~~~~~~~~~~~~~
  always @(frame_done) begin : compare_frame
    logic [report_bytes*8-1:0] got;
    logic [31:0]               lo;
    logic [31:0]               hi;
    got = '0;
    assert (rx_bytes.size() == report_bytes) else begin
      other_errors++;
      $display("Test %s: frame has %0d bytes", test_name, rx_bytes.size());
    end
    for (int i = 0; i < rx_bytes.size() && i < report_bytes; i++) begin
      got[i*8 +: 8] = rx_bytes[i];
    end
    check_value("sync", exp_frame[7:0], got[7:0]);
    check_value("bursts", exp_frame[23:8], got[23:8]);
    check_value("beats", exp_frame[55:24], got[55:24]);
    check_value("errors", exp_frame[95:88], got[95:88]);
    check_value("signature", exp_frame[127:96], got[127:96]);
    if (exp_count != 16'd0) begin
      // A beat takes wait_states idle cycles and one accept cycle
      lo = exp_frame[55:24] * 32'(wait_states + 1);
      hi = lo + 32'(exp_count) * 32'd8;
      assert (got[87:56] >= lo && got[87:56] <= hi) else begin
        value_errors++;
        $display("[ERROR] %s cycles: expected %0d to %0d, actual %0d",
                 test_name, lo, hi, got[87:56]);
      end
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~
  // Stimulus
  // ~~~~~~~~~~~~~~~~~~~~
  initial begin : stimulus
    logic [15:0] count;
    clk = 1'b0;
    rst = 1'b1;
    start = 1'b0;
    burst_count = '0;
    lfsr_state = 32'h4d60;
    value_errors = 0;
    other_errors = 0;
    exp_count = '0;
    exp_frame = '0;
    test_name = "reset";
    repeat (3) @(negedge clk);
    rst = 1'b0;

    check_line_quiet(20);
    run_once("single_burst", 16'd1, 1'b0, 16'd0);
    for (int r = 0; r < 5; r++) begin
      random_burst_count(count);
      run_once($sformatf("random_%0d", r), count, 1'b0, 16'd0);
    end
    run_once("zero_bursts", 16'd0, 1'b0, 16'd0);
    run_once("start_while_busy", 16'd3, 1'b1, 16'd9);

    $display("Errors: %0d wrong values, %0d other failures", value_errors, other_errors);
    if (value_errors == 0 && other_errors == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire
